// ==== vlog.f ====
adc_pkg.sv
sample_stream_if.sv
reg_bus_if.sv
adc_control_unit.sv
threshold_comparator.sv
sample_decimator.sv
sample_calibrator.sv
adc_processing.sv
adc_processing_asserts.sv
adc_processing_tb.sv

// ==== adc_processing_tb.sv ====
`timescale 1ns/100ps

module adc_processing_tb;
    import adc_pkg::*;

    localparam logic [31:0] BASE_ADDRESS    = 32'h43c00000;
    localparam int          MAX_SHIFT       = 4;
    localparam int          PLANNED_SAMPLES = 400;
    localparam longint      WATCHDOG_NS     = (200 * PLANNED_SAMPLES + 2000) * 10;
    localparam int          SHIFTS [3]      = '{0, 2, 4};

    // Readback values of word offsets 0 to 9
    localparam logic [31:0] RESET_VALUES [10] = '{32'h7fff, 32'h8000, 32'h7fff, 32'h8000,
        32'h0, 32'h1000, 32'h0, 32'h0, 32'h0, 32'h0};
    localparam logic [31:0] TEST_VALUES [10] = '{32'h1234, 32'h8765, 32'h0abc, 32'hf000,
        32'h0155, 32'h2000, 32'h9, 32'h7, 32'h0, 32'hf};

    logic        clock;
    logic        rst_n;
    logic        in_valid;
    sample_t     in_data;
    logic        in_ready;
    logic        out_valid;
    sample_t     out_data;
    logic        out_ready;
    logic        bus_valid;
    logic        bus_write;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_ready;
    logic [31:0] bus_rdata;
    logic        bus_rvalid;
    logic        fault;

    // Reference model state changes only while the pipeline is empty
    bit          stall_enable;
    int          shift_model;
    longint      offset_model;
    longint      gain_model;
    bit          gain_on;
    int          group_count;
    longint      group_sum;
    sample_t     expected_q[$];

    adc_processing #(
        .BASE_ADDRESS(BASE_ADDRESS),
        .MAX_SHIFT(MAX_SHIFT),
        .AVERAGING(1'b1)
    ) adc_processing_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("ERROR at %0d ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Offset, optional Q4.12 gain with floor rounding, then saturation
    function automatic sample_t expected_output(input longint decimated);
        longint value;
        value = decimated - offset_model;
        if (gain_on) begin
            value = (value * gain_model) >>> GAIN_FRAC_BITS;
        end
        if (value > 32767) begin
            value = 32767;
        end else if (value < -32768) begin
            value = -32768;
        end
        return sample_t'(value);
    endfunction

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic write_reg(input int index, input logic [31:0] value);
        bus_valid = 1'b1;
        bus_write = 1'b1;
        bus_addr  = BASE_ADDRESS + 32'(index) * 4;
        bus_wdata = value;
        do @(posedge clock); while (!bus_ready);
        #1;
        bus_valid = 1'b0;
        bus_write = 1'b0;
    endtask

    task automatic check_reg(input int index, input logic [31:0] expected);
        bus_valid = 1'b1;
        bus_write = 1'b0;
        bus_addr  = BASE_ADDRESS + 32'(index) * 4;
        do @(posedge clock); while (!bus_ready);
        #1;
        bus_valid = 1'b0;
        check_value("bus_rvalid", bus_rvalid, 1);
        check_value($sformatf("bus_rdata[%0d]", index), bus_rdata, expected);
    endtask

    task automatic send_sample(input sample_t value);
        in_data  = value;
        in_valid = 1'b1;
        do @(posedge clock); while (!in_ready);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_random(input int count);
        repeat (count) begin
            idle_cycles($urandom_range(2, 0));
            send_sample(sample_t'($urandom()));
        end
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            idle_cycles(1);
        end
    endtask

    task automatic configure(input int shift, input sample_t offset, input int gain,
                             input bit gain_en);
        write_reg(DECIM_SHIFT, 32'(shift));
        write_reg(OFFSET, {16'h0, offset});
        write_reg(GAIN, 32'(gain));
        write_reg(CONTROL, {29'h0, gain_en, 2'b00});
        shift_model  = shift;
        offset_model = offset;
        gain_model   = gain;
        gain_on      = gain_en;
        group_count  = 0;
        group_sum    = 0;
    endtask

    // Model of the decimator on raw transfers and checker on output transfers
    always @(posedge clock) begin
        if (rst_n && in_valid && in_ready) begin
            group_sum   += in_data;
            group_count += 1;
            if (group_count == (1 << shift_model)) begin
                expected_q.push_back(expected_output(group_sum >>> shift_model));
                group_sum   = 0;
                group_count = 0;
            end
        end
        if (rst_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("An output sample 0x%0h arrived with none outstanding", out_data);
                abort_run();
            end else begin
                check_value("out_data", out_data, expected_q.pop_front());
            end
        end
    end

    // A protocol assertion failure in the bound checker ends the run
    always @(posedge clock) begin
        if (adc_processing_i.asserts_i.failures != 0) begin
            $display("A protocol assertion on the DUT pins failed");
            abort_run();
        end
    end

    always @(posedge clock) begin
        #1;
        out_ready = stall_enable ? ($urandom_range(3, 0) != 0) : 1'b1;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        void'($urandom(32'h3f6f));
        rst_n        = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b1;
        bus_valid    = 1'b0;
        bus_write    = 1'b0;
        bus_addr     = '0;
        bus_wdata    = '0;
        stall_enable = 1'b0;
        shift_model  = 0;
        offset_model = 0;
        gain_model   = 4096;
        gain_on      = 1'b0;
        group_count  = 0;
        group_sum    = 0;
        // The falling edge puts every register in its reset state before the first clock edge
        #1 rst_n = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        check_value("out_valid", out_valid, 0);
        check_value("in_ready", in_ready, 0);
        check_value("fault", fault, 0);
        check_value("bus_rvalid", bus_rvalid, 0);
        check_value("bus_ready", bus_ready, 1);
        rst_n = 1'b1;
        idle_cycles(1);

        for (int i = 0; i < 10; i++) begin
            check_reg(i, RESET_VALUES[i]);
        end

        // STATUS is write-one-to-clear and is left out of the readback
        for (int i = 0; i < 10; i++) begin
            if (i != STATUS) begin
                write_reg(i, TEST_VALUES[i]);
                check_reg(i, (i == DECIM_SHIFT) ? 32'(MAX_SHIFT) : TEST_VALUES[i]);
            end
        end
        write_reg(10, 32'hffff);
        check_reg(10, 32'h0);
        // Word index 16 has the same low address bits as FAST_HIGH
        write_reg(16, 32'hffff);
        check_reg(16, 32'h0);
        check_reg(FAST_HIGH, TEST_VALUES[FAST_HIGH]);
        for (int i = 0; i < 10; i++) begin
            if (i != STATUS) begin
                write_reg(i, RESET_VALUES[i]);
            end
        end

        stall_enable = 1'b1;
        foreach (SHIFTS[i]) begin
            configure(SHIFTS[i], 0, 4096, 1'b0);
            send_random(32);
            wait_drain();
            configure(SHIFTS[i], 300, 6000, 1'b1);
            send_random(32);
            wait_drain();
            configure(SHIFTS[i], -20000, 4096, 1'b0);
            send_random(32);
            wait_drain();
            configure(SHIFTS[i], -20000, 12288, 1'b1);
            send_random(32);
            wait_drain();
        end
        stall_enable = 1'b0;

        // Fast comparator in latching mode, then in following mode
        configure(0, 0, 4096, 1'b0);
        write_reg(FAST_HIGH, 32'd1000);
        write_reg(FAULT_MASK, 32'h1);
        write_reg(CONTROL, 32'h1);
        send_sample(2000);
        idle_cycles(3);
        check_value("fault", fault, 1);
        check_reg(STATUS, 32'h1);
        send_sample(100);
        wait_drain();
        idle_cycles(2);
        check_value("fast_trip_high", adc_processing_i.fast_trip_high, 1);
        check_value("fault", fault, 1);
        write_reg(STATUS, 32'h1);
        idle_cycles(2);
        check_value("fault", fault, 0);
        check_reg(STATUS, 32'h0);
        write_reg(CONTROL, 32'h0);
        send_sample(2000);
        idle_cycles(1);
        check_value("fast_trip_high", adc_processing_i.fast_trip_high, 1);
        send_sample(100);
        check_value("fast_trip_high", adc_processing_i.fast_trip_high, 0);
        wait_drain();
        write_reg(STATUS, 32'h1);
        idle_cycles(2);
        check_reg(STATUS, 32'h0);
        check_value("fault", fault, 0);

        // Group average -1150 falls below SLOW_LOW while every raw sample stays above FAST_LOW
        configure(2, 0, 4096, 1'b0);
        write_reg(FAST_LOW, {16'h0, sample_t'(-1500)});
        write_reg(SLOW_LOW, {16'h0, sample_t'(-1000)});
        write_reg(STATUS, 32'hf);
        send_sample(-1400);
        send_sample(-1400);
        send_sample(-1400);
        send_sample(-400);
        wait_drain();
        idle_cycles(2);
        check_reg(STATUS, 32'h8);
        check_value("fault", fault, 0);
        idle_cycles(4);

        if (adc_processing_i.asserts_i.failures == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Protocol assertions failed %0d times",
                     adc_processing_i.asserts_i.failures);
            $display("STATUS: FAIL");
            $fatal(1, "Protocol assertions failed");
        end
    end

endmodule

// ==== adc_processing_asserts.sv ====
`timescale 1ns/100ps

// Protocol checks on the top-level pins of the DUT
module adc_processing_asserts (
    input logic             clock,
    input logic             rst_n,
    input logic             out_valid,
    input logic             out_ready,
    input adc_pkg::sample_t out_data,
    input logic             bus_valid,
    input logic             bus_write,
    input logic             bus_ready,
    input logic             bus_rvalid,
    input logic             fault
);

    // Read by the testbench at the end of the run
    int failures = 0;

    // A stalled output sample must not change until it is taken
    assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        $error("out_valid or out_data changed during a stall");
        failures++;
    end

    // Read data returns exactly one cycle after the read was accepted
    assert property (@(posedge clock) disable iff (!rst_n)
        bus_rvalid == $past(bus_valid && bus_ready && !bus_write))
    else begin
        $error("bus_rvalid does not follow an accepted read by one cycle");
        failures++;
    end

    assert property (@(posedge clock) disable iff (!rst_n) bus_rvalid |-> !bus_ready)
    else begin
        $error("bus_ready is high while bus_rvalid is high");
        failures++;
    end

    assert property (@(posedge clock) !rst_n |-> !fault && !out_valid)
    else begin
        $error("fault or out_valid is high during reset");
        failures++;
    end

endmodule

bind adc_processing adc_processing_asserts asserts_i (.*);

// ==== adc_processing.sv ====
`timescale 1ns/100ps

module adc_processing #(
    parameter logic [31:0] BASE_ADDRESS = 32'h43c00000,
    parameter int          MAX_SHIFT    = 4,
    parameter bit          AVERAGING    = 1'b1
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             in_valid,
    input  adc_pkg::sample_t in_data,
    output logic             in_ready,
    output logic             out_valid,
    output adc_pkg::sample_t out_data,
    input  logic             out_ready,
    input  logic             bus_valid,
    input  logic             bus_write,
    input  logic [31:0]      bus_addr,
    input  logic [31:0]      bus_wdata,
    output logic             bus_ready,
    output logic [31:0]      bus_rdata,
    output logic             bus_rvalid,
    output logic             fault
);
    import adc_pkg::*;

    sample_stream_if raw ();
    sample_stream_if decimated ();
    sample_stream_if calibrated ();
    reg_bus_if       bus ();

    sample_t                          fast_high;
    sample_t                          fast_low;
    sample_t                          slow_high;
    sample_t                          slow_low;
    sample_t                          offset;
    gain_t                            gain;
    logic [$clog2(MAX_SHIFT + 1)-1:0] decim_shift;
    logic                             shift_written;
    control_t                         control;
    trip_t                            trip_clear;
    trip_t                            trips;
    logic                             fast_trip_high;
    logic                             fast_trip_low;
    logic                             slow_trip_high;
    logic                             slow_trip_low;

    assign raw.valid = in_valid;
    assign raw.data  = in_data;
    assign in_ready  = raw.ready;

    assign out_valid        = calibrated.valid;
    assign out_data         = calibrated.data;
    assign calibrated.ready = out_ready;

    assign bus.valid  = bus_valid;
    assign bus.write  = bus_write;
    assign bus.addr   = bus_addr;
    assign bus.wdata  = bus_wdata;
    assign bus_ready  = bus.ready;
    assign bus_rdata  = bus.rdata;
    assign bus_rvalid = bus.rvalid;

    assign trips = '{slow_low:  slow_trip_low,  slow_high: slow_trip_high,
                     fast_low:  fast_trip_low,  fast_high: fast_trip_high};

    adc_control_unit #(.BASE_ADDRESS(BASE_ADDRESS), .MAX_SHIFT(MAX_SHIFT)) control_unit (
        .clock(clock), .rst_n(rst_n), .bus(bus), .trips(trips),
        .fast_high(fast_high), .fast_low(fast_low),
        .slow_high(slow_high), .slow_low(slow_low),
        .offset(offset), .gain(gain),
        .decim_shift(decim_shift), .shift_written(shift_written),
        .control(control), .trip_clear(trip_clear), .fault(fault)
    );

    // The fast comparator watches every raw transfer
    threshold_comparator fast_cmp (
        .clock(clock), .rst_n(rst_n),
        .sample(raw.data), .sample_taken(raw.valid & raw.ready),
        .high_threshold(fast_high), .low_threshold(fast_low),
        .latching(control.fast_latch),
        .clear({trip_clear.fast_low, trip_clear.fast_high}),
        .trip_high(fast_trip_high), .trip_low(fast_trip_low)
    );

    sample_decimator #(.MAX_SHIFT(MAX_SHIFT), .AVERAGING(AVERAGING)) decimator (
        .clock(clock), .rst_n(rst_n), .in(raw), .out(decimated),
        .shift(decim_shift), .restart(shift_written)
    );

    // The slow comparator sees the decimated stream before calibration
    threshold_comparator slow_cmp (
        .clock(clock), .rst_n(rst_n),
        .sample(decimated.data), .sample_taken(decimated.valid & decimated.ready),
        .high_threshold(slow_high), .low_threshold(slow_low),
        .latching(control.slow_latch),
        .clear({trip_clear.slow_low, trip_clear.slow_high}),
        .trip_high(slow_trip_high), .trip_low(slow_trip_low)
    );

    sample_calibrator calibrator (
        .clock(clock), .rst_n(rst_n), .in(decimated), .out(calibrated),
        .offset(offset), .gain(gain), .gain_enable(control.gain_enable)
    );

endmodule

// ==== sample_calibrator.sv ====
`timescale 1ns/100ps

module sample_calibrator (
    input  logic             clock,
    input  logic             rst_n,
    sample_stream_if.sink    in,
    sample_stream_if.source  out,
    input  adc_pkg::sample_t offset,
    input  adc_pkg::gain_t   gain,
    input  logic             gain_enable
);
    import adc_pkg::*;

    logic               s1_valid;
    logic signed [16:0] s1_diff;
    logic               s2_valid;
    sample_t            s2_data;
    logic               advance;
    logic signed [33:0] product;
    logic signed [33:0] scaled;
    logic signed [33:0] stage2_value;

    function automatic sample_t saturate(input logic signed [33:0] value);
        if (value > $signed(SAMPLE_MAX)) begin
            return SAMPLE_MAX;
        end
        if (value < $signed(SAMPLE_MIN)) begin
            return SAMPLE_MIN;
        end
        return sample_t'(value);
    endfunction

    // Stage two is free when it is empty or its sample leaves this cycle
    assign advance  = ~s2_valid | out.ready;
    assign in.ready = advance | ~s1_valid;

    assign out.valid = s2_valid;
    assign out.data  = s2_data;

    // Gain is unsigned, so it gets a zero sign bit before the signed multiply
    assign product      = s1_diff * $signed({1'b0, gain});
    assign scaled       = product >>> GAIN_FRAC_BITS;
    assign stage2_value = gain_enable ? scaled : 34'(s1_diff);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (advance) begin
                s2_valid <= s1_valid;
            end
            if (in.ready) begin
                s1_valid <= in.valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        // The difference of two 16-bit samples needs the extra bit
        if (in.valid && in.ready) begin
            s1_diff <= $signed({in.data[15], in.data}) - $signed({offset[15], offset});
        end
        if (advance && s1_valid) begin
            s2_data <= saturate(stage2_value);
        end
    end

endmodule

// ==== sample_decimator.sv ====
`timescale 1ns/100ps

module sample_decimator #(
    parameter int MAX_SHIFT = 4,
    parameter bit AVERAGING = 1'b1
) (
    input  logic                               clock,
    input  logic                               rst_n,
    sample_stream_if.sink                      in,
    sample_stream_if.source                    out,
    input  logic [$clog2(MAX_SHIFT + 1) - 1:0] shift,
    input  logic                               restart
);
    import adc_pkg::*;

    localparam int ACC_W = $bits(sample_t) + MAX_SHIFT;
    localparam int CNT_W = MAX_SHIFT + 1;

    logic                    active;
    logic                    out_valid_q;
    sample_t                 out_data_q;
    logic [CNT_W-1:0]        count;
    logic [CNT_W-1:0]        count_base;
    logic [CNT_W-1:0]        group_len;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] acc_base;
    logic signed [ACC_W-1:0] sum_next;
    logic signed [ACC_W-1:0] sum_scaled;
    logic                    in_fire;
    logic                    group_done;

    // Input stays off until the cycle after reset is released
    assign in.ready  = active & (~out_valid_q | out.ready);
    assign out.valid = out_valid_q;
    assign out.data  = out_data_q;

    assign in_fire   = in.valid & in.ready;
    assign group_len = CNT_W'(1) << shift;

    // A pending restart makes the next accepted sample the first of a group
    assign count_base = restart ? '0 : count;
    assign acc_base   = restart ? '0 : acc;

    assign sum_next   = acc_base + ACC_W'(in.data);
    assign sum_scaled = sum_next >>> shift;
    assign group_done = (count_base + CNT_W'(1)) == group_len;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            out_valid_q <= 1'b0;
            count       <= '0;
            acc         <= '0;
        end else begin
            active <= 1'b1;
            if (out_valid_q && out.ready) begin
                out_valid_q <= 1'b0;
            end
            if (in_fire) begin
                if (group_done) begin
                    out_valid_q <= 1'b1;
                    count       <= '0;
                    acc         <= '0;
                end else begin
                    count <= count_base + CNT_W'(1);
                    acc   <= sum_next;
                end
            end else if (restart) begin
                count <= '0;
                acc   <= '0;
            end
        end
    end

    // Output holding register
    always_ff @(posedge clock) begin
        if (in_fire && group_done) begin
            out_data_q <= AVERAGING ? sample_t'(sum_scaled) : in.data;
        end
    end

endmodule

// ==== threshold_comparator.sv ====
`timescale 1ns/100ps

module threshold_comparator (
    input  logic             clock,
    input  logic             rst_n,
    input  adc_pkg::sample_t sample,
    input  logic             sample_taken,
    input  adc_pkg::sample_t high_threshold,
    input  adc_pkg::sample_t low_threshold,
    input  logic             latching,
    input  logic [1:0]       clear,
    output logic             trip_high,
    output logic             trip_low
);
    import adc_pkg::*;

    logic above;
    logic below;

    // Strict comparisons, a sample equal to a threshold does not trip
    assign above = sample > high_threshold;
    assign below = sample < low_threshold;

    // Bit 0 of clear belongs to the high trip and bit 1 to the low trip
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            trip_high <= 1'b0;
            trip_low  <= 1'b0;
        end else if (latching) begin
            // A new crossing on the clearing edge keeps the flag set
            trip_high <= (trip_high & ~clear[0]) | (sample_taken & above);
            trip_low  <= (trip_low & ~clear[1]) | (sample_taken & below);
        end else if (sample_taken) begin
            trip_high <= above;
            trip_low  <= below;
        end else begin
            // Between transfers the flags still honour a clear
            if (clear[0]) begin
                trip_high <= 1'b0;
            end
            if (clear[1]) begin
                trip_low <= 1'b0;
            end
        end
    end

endmodule

// ==== adc_control_unit.sv ====
`timescale 1ns/100ps

module adc_control_unit #(
    parameter logic [31:0] BASE_ADDRESS = 32'h43c00000,
    parameter int          MAX_SHIFT    = 4
) (
    input  logic                                 clock,
    input  logic                                 rst_n,
    reg_bus_if.slave                             bus,
    input  adc_pkg::trip_t                       trips,
    output adc_pkg::sample_t                     fast_high,
    output adc_pkg::sample_t                     fast_low,
    output adc_pkg::sample_t                     slow_high,
    output adc_pkg::sample_t                     slow_low,
    output adc_pkg::sample_t                     offset,
    output adc_pkg::gain_t                       gain,
    output logic [$clog2(MAX_SHIFT + 1) - 1:0]   decim_shift,
    output logic                                 shift_written,
    output adc_pkg::control_t                    control,
    output adc_pkg::trip_t                       trip_clear,
    output logic                                 fault
);
    import adc_pkg::*;

    localparam int SHIFT_W = $clog2(MAX_SHIFT + 1);

    logic [31:0]        byte_offset;
    logic [29:0]        word_index;
    logic               in_range;
    reg_addr_e          reg_sel;
    logic               accept;
    logic               write_hit;
    logic [SHIFT_W-1:0] shift_clamped;
    logic [31:0]        read_value;
    logic [31:0]        rdata_q;
    logic               rvalid_q;
    trip_t              status;
    trip_t              status_next;
    trip_t              fault_mask;

    // Word index relative to the block base, anything below the base wraps out of range
    assign byte_offset = bus.addr - BASE_ADDRESS;
    assign word_index  = byte_offset[31:2];
    assign in_range    = word_index <= 30'(FAULT_MASK);
    assign reg_sel     = reg_addr_e'(word_index[3:0]);

    // A read blocks the bus for the cycle in which its data returns
    assign bus.ready  = ~rvalid_q;
    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

    assign accept    = bus.valid & bus.ready;
    assign write_hit = accept & bus.write & in_range;

    assign shift_clamped = (bus.wdata > 32'(MAX_SHIFT)) ? SHIFT_W'(MAX_SHIFT)
                                                        : bus.wdata[SHIFT_W-1:0];

    // Clear pulse reaches the comparators on the same edge that clears STATUS
    assign trip_clear = (write_hit && reg_sel == STATUS) ? trip_t'(bus.wdata[3:0])
                                                          : trip_t'(4'b0000);

    // Cleared bits win over a trip that is still high on the clearing edge
    assign status_next = (status | trips) & ~trip_clear;

    always_comb begin
        read_value = 32'h0;
        if (in_range) begin
            case (reg_sel)
                FAST_HIGH:   read_value = {16'h0, fast_high};
                FAST_LOW:    read_value = {16'h0, fast_low};
                SLOW_HIGH:   read_value = {16'h0, slow_high};
                SLOW_LOW:    read_value = {16'h0, slow_low};
                OFFSET:      read_value = {16'h0, offset};
                GAIN:        read_value = {16'h0, gain};
                DECIM_SHIFT: read_value = 32'(decim_shift);
                CONTROL:     read_value = 32'(control);
                STATUS:      read_value = 32'(status);
                FAULT_MASK:  read_value = 32'(fault_mask);
                default:     read_value = 32'h0;
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fast_high     <= SAMPLE_MAX;
            fast_low      <= SAMPLE_MIN;
            slow_high     <= SAMPLE_MAX;
            slow_low      <= SAMPLE_MIN;
            offset        <= '0;
            gain          <= gain_t'(1 << GAIN_FRAC_BITS);
            decim_shift   <= '0;
            shift_written <= 1'b0;
            control       <= '0;
            fault_mask    <= '0;
            status        <= '0;
            fault         <= 1'b0;
            rvalid_q      <= 1'b0;
        end else begin
            rvalid_q      <= accept & ~bus.write;
            shift_written <= write_hit && reg_sel == DECIM_SHIFT;
            status        <= status_next;
            fault         <= |(status_next & fault_mask);
            if (write_hit) begin
                case (reg_sel)
                    FAST_HIGH:   fast_high   <= sample_t'(bus.wdata[15:0]);
                    FAST_LOW:    fast_low    <= sample_t'(bus.wdata[15:0]);
                    SLOW_HIGH:   slow_high   <= sample_t'(bus.wdata[15:0]);
                    SLOW_LOW:    slow_low    <= sample_t'(bus.wdata[15:0]);
                    OFFSET:      offset      <= sample_t'(bus.wdata[15:0]);
                    GAIN:        gain        <= gain_t'(bus.wdata[15:0]);
                    DECIM_SHIFT: decim_shift <= shift_clamped;
                    CONTROL:     control     <= control_t'(bus.wdata[2:0]);
                    FAULT_MASK:  fault_mask  <= trip_t'(bus.wdata[3:0]);
                    default:     ;
                endcase
            end
        end
    end

    // Read data is captured on the accepting edge
    always_ff @(posedge clock) begin
        if (accept && !bus.write) begin
            rdata_q <= read_value;
        end
    end

endmodule

// ==== reg_bus_if.sv ====
`timescale 1ns/100ps

// Memory-mapped register bus, one outstanding read at a time
interface reg_bus_if;

    logic        valid;
    logic        ready;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rvalid;

    modport master (
        output valid,
        output write,
        output addr,
        output wdata,
        input  ready,
        input  rdata,
        input  rvalid
    );

    modport slave (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        output ready,
        output rdata,
        output rvalid
    );

endinterface

// ==== sample_stream_if.sv ====
`timescale 1ns/100ps

// Sample stream with a valid/ready handshake
interface sample_stream_if;
    import adc_pkg::*;

    logic    valid;
    logic    ready;
    sample_t data;

    // The producer side holds valid and data stable while ready is low
    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

// ==== adc_pkg.sv ====
package adc_pkg;

    // Raw and processed ADC samples are two's complement
    typedef logic signed [15:0] sample_t;

    // Unsigned Q4.12 gain where 4096 is unity
    typedef logic [15:0] gain_t;

    localparam int GAIN_FRAC_BITS = 12;

    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = -16'sh8000;

    // Word offsets from the base address of the register block
    typedef enum logic [3:0] {
        FAST_HIGH   = 4'd0,
        FAST_LOW    = 4'd1,
        SLOW_HIGH   = 4'd2,
        SLOW_LOW    = 4'd3,
        OFFSET      = 4'd4,
        GAIN        = 4'd5,
        DECIM_SHIFT = 4'd6,
        CONTROL     = 4'd7,
        STATUS      = 4'd8,
        FAULT_MASK  = 4'd9
    } reg_addr_e;

    // fast_latch sits in bit 0
    typedef struct packed {
        logic gain_enable;
        logic slow_latch;
        logic fast_latch;
    } control_t;

    // fast_high sits in bit 0, the same layout as the STATUS register
    typedef struct packed {
        logic slow_low;
        logic slow_high;
        logic fast_low;
        logic fast_high;
    } trip_t;

endpackage
